/* tb/parity_link_trace.txt */
# opcode (C parity sense, W word) | data hex (for C: 1 even, 0 odd) | inject mask hex
# | consumer stall cycles before the pop, decimal, -1 picks a random stall of 0..3
C 1 0 0
W 00000000 0 0
W ffffffff 0 0
W 12345678 0 0
W deadbeef 0 0
W a5a5a5a5 0 0
W 0f1e2d3c 0 0
W 11111111 1 0
W 80000001 2 0
W c0ffee00 4 1
W 7654321f f 0
C 0 0 0
W 00000000 0 0
W 13579bdf 0 0
W fedcba98 0 2
W 00ff00ff 0 0
W 5a5a5a5a 0 0
W 01020304 8 0
W 9abcdef0 5 0
W 33333333 a 0
W 44444444 3 1
W cafef00d 0 40
W 10000000 0 0
W 20000000 1 0
W 30000000 0 0
W 40000000 2 0
W 50000000 0 0
W 60000000 4 0
W 70000000 0 0
W 0badf00d 0 -1
W 1badb002 6 -1
W 2468ace0 0 -1
W 87654321 9 -1
W 0000ffff 0 -1
W ffff0000 c -1
W 3c3c3c3c 0 -1
W e1e1e1e1 1 -1
W 6b6b6b6b 0 -1
W 99999999 f -1
W 01234567 0 -1
W 89abcdef 2 -1
W 55aa55aa 0 -1
W aa55aa55 8 -1
C 1 0 0
W 0000000f 0 -1
W f0000000 7 -1
W 7fffffff 0 0

/* filelist.f */
design/parity_link_pkg.sv
design/dataint_parity.sv
design/credit_link_if.sv
design/link_tx.sv
design/link_rx_buffer.sv
design/parity_link_top.sv
tb/parity_link_chk.sv
tb/parity_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the word link testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module parity_link_tb \
    --Mdir obj_dir \
    -o parity_link_sim

./obj_dir/parity_link_sim 2>&1 | tee sim.log

if grep -q "^Test passed$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* tb/parity_link_tb.sv */
// Trace-driven testbench for the parity-protected word link.
// Reads words, inject masks and consumer stalls from the trace file, then runs
// a producer and a consumer in parallel and checks every word that leaves.

`timescale 1ns/1ps

module parity_link_tb;

    import parity_link_pkg::*;

    localparam int    WIDTH      = LINK_WIDTH;
    localparam int    CHUNKS     = LINK_CHUNKS;
    localparam int    DEPTH      = LINK_DEPTH;
    localparam int    WAIT_LIMIT = 200;
    localparam string TRACE_FILE = "tb/parity_link_trace.txt";

    logic       clk;
    logic       rst_n;
    logic       parity_type;
    logic       in_valid;
    link_data_t in_data;
    link_par_t  in_inject;
    logic       in_ready;
    logic       out_valid;
    link_data_t out_data;
    link_par_t  out_parity_err;
    logic       out_ready;

    // Trace lines in file order
    byte        tr_op[$];
    link_data_t tr_val[$];
    link_par_t  tr_mask[$];
    int         tr_stall[$];
    int         word_total;

    // Words sent but not yet checked, oldest first
    link_data_t exp_data_q[$];
    link_par_t  exp_mask_q[$];
    int         exp_stall_q[$];

    int          sent;
    int          popped;
    int          credited = 0;
    bit          saw_full;

    parity_link_top #(
        .WIDTH (WIDTH),
        .CHUNKS(CHUNKS),
        .DEPTH (DEPTH)
    ) parity_link_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .parity_type   (parity_type),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_inject     (in_inject),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_parity_err(out_parity_err),
        .out_ready     (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // A popped word's credit is back at the transmitter one edge later
    always @(posedge clk) begin
        credited <= popped;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic expect_eq(input string name, input logic [63:0] want,
                             input logic [63:0] got);
        if (got !== want) begin
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, want, got);
            fail_run("value check failed");
        end
    endtask

    // Inputs change 2 ns after the rising edge, outputs are sampled there too
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic load_trace();
        int          fd;
        int          fields;
        string       line;
        byte         op;
        logic [31:0] val;
        logic [31:0] msk;
        int          stl;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            fail_run("cannot open the trace file");
        end else begin
            word_total = 0;
            while ($fgets(line, fd) != 0) begin
                op = line.getc(0);
                // Comment and blank lines carry no opcode
                if (op == "W" || op == "C") begin
                    fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %d",
                                     val, msk, stl);
                    if (fields != 3) begin
                        fail_run({"malformed trace line: ", line});
                    end else begin
                        tr_op.push_back(op);
                        tr_val.push_back(link_data_t'(val));
                        tr_mask.push_back(link_par_t'(msk));
                        tr_stall.push_back(stl);
                        if (op == "W") begin
                            word_total++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------------
    // Producer
    // ------------------------------------------------------------------------

    task automatic send_word(input link_data_t data, input link_par_t mask,
                             input int stall);
        int waited;
        waited = 0;
        // Ready exactly while fewer than DEPTH words hold a credit
        expect_eq("in_ready", 64'((sent - credited) < DEPTH), 64'(in_ready));
        while (!in_ready) begin
            saw_full = 1'b1;
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("timed out waiting for in_ready");
            end
            expect_eq("in_ready", 64'((sent - credited) < DEPTH), 64'(in_ready));
        end
        in_valid  = 1'b1;
        in_data   = data;
        in_inject = mask;
        exp_data_q.push_back(data);
        exp_mask_q.push_back(mask);
        exp_stall_q.push_back(stall);
        sent++;
        next_cycle();
        in_valid = 1'b0;
    endtask

    // Parity sense may only change with nothing stored or in flight
    task automatic wait_link_empty();
        int waited;
        waited = 0;
        while (credited != sent || out_valid) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("timed out waiting for the link to drain");
            end
        end
    endtask

    task automatic run_producer();
        for (int i = 0; i < tr_op.size(); i++) begin
            if (tr_op[i] == "C") begin
                wait_link_empty();
                parity_type = tr_val[i][0];
            end else begin
                send_word(tr_val[i], tr_mask[i], tr_stall[i]);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Consumer
    // ------------------------------------------------------------------------

    task automatic take_word();
        link_data_t want_data;
        link_par_t  want_err;
        int         stall;
        int         waited;
        waited = 0;
        while (!out_valid) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("timed out waiting for out_valid");
            end
        end
        if (exp_data_q.size() == 0) begin
            fail_run("a word came out that was never sent");
        end
        want_data = exp_data_q.pop_front();
        // Injected flips show up one for one as error flags
        want_err  = exp_mask_q.pop_front();
        stall     = exp_stall_q.pop_front();
        if (stall < 0) begin
            stall = $urandom_range(3, 0);
        end
        repeat (stall) next_cycle();
        expect_eq("out_valid", 64'(1), 64'(out_valid));
        expect_eq("out_data", 64'(want_data), 64'(out_data));
        expect_eq("out_parity_err", 64'(want_err), 64'(out_parity_err));
        out_ready = 1'b1;
        next_cycle();
        out_ready = 1'b0;
        popped++;
    endtask

    task automatic run_consumer();
        for (int n = 0; n < word_total; n++) begin
            take_word();
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        rst_n       = 1'b0;
        parity_type = 1'b1;
        in_valid    = 1'b0;
        in_data     = '0;
        in_inject   = '0;
        out_ready   = 1'b0;
        sent        = 0;
        popped      = 0;
        saw_full    = 1'b0;
        void'($urandom(93));
        load_trace();
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        expect_eq("in_ready", 64'(1), 64'(in_ready));
        expect_eq("out_valid", 64'(0), 64'(out_valid));
        fork
            run_producer();
            run_consumer();
        join
        next_cycle();
        expect_eq("out_valid", 64'(0), 64'(out_valid));
        if (!saw_full) begin
            fail_run("in_ready never dropped during the long consumer stall");
        end else if (parity_link_top_i.link_tx_i.tx_chk_i.fail_cnt != 0 ||
                     parity_link_top_i.link_rx_buffer_i.rx_chk_i.fail_cnt != 0) begin
            fail_run("a bound assertion failed during the run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule : parity_link_tb

/* tb/parity_link_chk.sv */
// Bound assertions on the credit and consumer handshake rules.
// One instance sits in the transmitter, one in the receive buffer;
// ports that do not belong to that side are tied off in the bind.

`timescale 1ns/1ps

module parity_link_chk #(
    parameter int WIDTH  = parity_link_pkg::LINK_WIDTH,
    parameter int CHUNKS = parity_link_pkg::LINK_CHUNKS,
    parameter int DEPTH  = parity_link_pkg::LINK_DEPTH,
    parameter int CNT_W  = 3
) (
    input logic                         clk,
    input logic                         rst_n,
    input parity_link_pkg::credit_cnt_t credit_cnt,
    input logic                         link_valid,
    input logic                         out_valid,
    input logic                         out_ready,
    input logic [WIDTH-1:0]             out_data,
    input logic [CHUNKS-1:0]            out_parity_err,
    input logic [CNT_W-1:0]             fill_cnt
);

    import parity_link_pkg::*;

    // Count of failed assertions
    int unsigned fail_cnt = 0;

    // Never more credits than buffer entries
    credit_max_a : assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= credit_cnt_t'(DEPTH))
        else begin
            $error("credit count above buffer depth");
            fail_cnt++;
        end

    // A link word needs a credit at its accepting edge
    credit_spend_a : assert property (@(posedge clk) disable iff (!rst_n)
        link_valid |-> $past(credit_cnt) != '0)
        else begin
            $error("link word sent without a credit");
            fail_cnt++;
        end

    // Head word holds while the consumer stalls
    out_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(out_data) && $stable(out_parity_err))
        else begin
            $error("consumer outputs changed during a stall");
            fail_cnt++;
        end

    // Occupancy bound
    fill_max_a : assert property (@(posedge clk) disable iff (!rst_n)
        fill_cnt <= CNT_W'(DEPTH))
        else begin
            $error("buffer occupancy above depth");
            fail_cnt++;
        end

endmodule : parity_link_chk

bind link_tx parity_link_chk #(
    .WIDTH (WIDTH),
    .CHUNKS(CHUNKS),
    .DEPTH (DEPTH),
    .CNT_W (1)
) tx_chk_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .credit_cnt    (credit_cnt),
    .link_valid    (link.link_valid),
    .out_valid     (1'b0),
    .out_ready     (1'b1),
    .out_data      ('0),
    .out_parity_err('0),
    .fill_cnt      ('0)
);

bind link_rx_buffer parity_link_chk #(
    .WIDTH (WIDTH),
    .CHUNKS(CHUNKS),
    .DEPTH (DEPTH),
    .CNT_W ($clog2(DEPTH + 1))
) rx_chk_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .credit_cnt    ('0),
    .link_valid    (1'b0),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_data      (out_data),
    .out_parity_err(out_parity_err),
    .fill_cnt      (fill_cnt)
);

/* design/parity_link_top.sv */
// Top level of the parity-protected, credit-flow-controlled word link.
// Producer words enter on in_*, consumer words leave on out_*.
// parity_type selects even (1) or odd (0) parity; change it only when empty.

`timescale 1ns/1ps

module parity_link_top #(
    parameter int WIDTH  = parity_link_pkg::LINK_WIDTH,
    parameter int CHUNKS = parity_link_pkg::LINK_CHUNKS,
    parameter int DEPTH  = parity_link_pkg::LINK_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              parity_type,
    // Producer side
    input  logic              in_valid,
    input  logic [WIDTH-1:0]  in_data,
    input  logic [CHUNKS-1:0] in_inject,
    output logic              in_ready,
    // Consumer side
    output logic              out_valid,
    output logic [WIDTH-1:0]  out_data,
    output logic [CHUNKS-1:0] out_parity_err,
    input  logic              out_ready
);

    // Link between the two halves
    credit_link_if #(
        .WIDTH (WIDTH),
        .CHUNKS(CHUNKS)
    ) link_if_i ();

    link_tx #(
        .WIDTH (WIDTH),
        .CHUNKS(CHUNKS),
        .DEPTH (DEPTH)
    ) link_tx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_inject  (in_inject),
        .parity_type(parity_type),
        .in_ready   (in_ready),
        .link       (link_if_i.tx)
    );

    link_rx_buffer #(
        .WIDTH (WIDTH),
        .CHUNKS(CHUNKS),
        .DEPTH (DEPTH)
    ) link_rx_buffer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .link          (link_if_i.rx),
        .parity_type   (parity_type),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_parity_err(out_parity_err)
    );

endmodule : parity_link_top

/* design/link_rx_buffer.sv */
// Receive buffer for the word link. Stores data with its parity in a
// circular FIFO, re-checks parity on the head entry and offers it to the
// consumer. Each pop sends one registered credit back to the transmitter.

`timescale 1ns/1ps

module link_rx_buffer #(
    parameter int WIDTH  = parity_link_pkg::LINK_WIDTH,
    parameter int CHUNKS = parity_link_pkg::LINK_CHUNKS,
    parameter int DEPTH  = parity_link_pkg::LINK_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    credit_link_if.rx         link,
    input  logic              parity_type,
    input  logic              out_ready,
    output logic              out_valid,
    output logic [WIDTH-1:0]  out_data,
    output logic [CHUNKS-1:0] out_parity_err
);

    // Pointer and occupancy widths
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // ------------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------------

    logic [WIDTH-1:0]  data_mem [DEPTH];
    logic [CHUNKS-1:0] par_mem  [DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fill_cnt;

    logic              push;
    logic              pop;

    // Credits guarantee room, so every link word is written
    assign push = link.link_valid;
    assign pop  = out_valid & out_ready;

    // Entry write at the write pointer
    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= link.link_data;
            par_mem[wr_ptr]  <= link.link_parity;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else begin
            case ({push, pop})
                2'b10:   fill_cnt <= fill_cnt + CNT_W'(1);
                2'b01:   fill_cnt <= fill_cnt - CNT_W'(1);
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Consumer side
    // ------------------------------------------------------------------------

    // Head entry is presented as long as anything is stored
    assign out_valid = (fill_cnt != '0);
    assign out_data  = data_mem[rd_ptr];

    // Check the head against its stored parity
    dataint_parity #(
        .CHUNKS(CHUNKS),
        .WIDTH (WIDTH)
    ) rx_check_i (
        .data_in    (out_data),
        .parity_in  (par_mem[rd_ptr]),
        .parity_type(parity_type),
        .parity     (),
        .parity_err (out_parity_err)
    );

    // One credit back per pop, a cycle after the popping edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link.credit_ret <= 1'b0;
        end else begin
            link.credit_ret <= pop;
        end
    end

endmodule : link_rx_buffer

/* design/link_tx.sv */
// Link transmitter. Holds the credit count, generates per-chunk parity,
// applies the error-injection mask and registers each word onto the link.
// A producer word is taken on any edge with in_valid and in_ready high.

`timescale 1ns/1ps

module link_tx #(
    parameter int WIDTH  = parity_link_pkg::LINK_WIDTH,
    parameter int CHUNKS = parity_link_pkg::LINK_CHUNKS,
    parameter int DEPTH  = parity_link_pkg::LINK_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic [WIDTH-1:0]  in_data,
    input  logic [CHUNKS-1:0] in_inject,
    input  logic              parity_type,
    output logic              in_ready,
    credit_link_if.tx         link
);

    import parity_link_pkg::*;

    // ------------------------------------------------------------------------
    // Credit accounting
    // ------------------------------------------------------------------------

    credit_cnt_t       credit_cnt;
    logic              accept;
    logic [CHUNKS-1:0] gen_parity;

    // Any credit left means the buffer has room
    assign in_ready = (credit_cnt != '0);
    assign accept   = in_valid & in_ready;

    // Spend on accept, refill on credit_ret; both together cancel out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= credit_cnt_t'(DEPTH);
        end else begin
            case ({accept, link.credit_ret})
                2'b10:   credit_cnt <= credit_cnt - credit_cnt_t'(1);
                2'b01:   credit_cnt <= credit_cnt + credit_cnt_t'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Parity generation
    // ------------------------------------------------------------------------

    // Generation only, so no reference parity and no error flags
    dataint_parity #(
        .CHUNKS(CHUNKS),
        .WIDTH (WIDTH)
    ) tx_parity_i (
        .data_in    (in_data),
        .parity_in  ('0),
        .parity_type(parity_type),
        .parity     (gen_parity),
        .parity_err ()
    );

    // ------------------------------------------------------------------------
    // Registered link stage
    // ------------------------------------------------------------------------

    // Valid is a single-cycle pulse per accepted word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link.link_valid <= 1'b0;
        end else begin
            link.link_valid <= accept;
        end
    end

    // Payload, with injected flips on the chosen parity bits
    always_ff @(posedge clk) begin
        if (accept) begin
            link.link_data   <= in_data;
            link.link_parity <= gen_parity ^ in_inject;
        end
    end

endmodule : link_tx

/* design/credit_link_if.sv */
// Word link between transmitter and receive buffer.
// The tx side sends one word with its parity per link_valid pulse,
// the rx side hands back one credit per credit_ret pulse.

`timescale 1ns/1ps

interface credit_link_if #(
    parameter int WIDTH  = parity_link_pkg::LINK_WIDTH,
    parameter int CHUNKS = parity_link_pkg::LINK_CHUNKS
);

    // Forward path, one-cycle pulse per word
    logic              link_valid;
    logic [WIDTH-1:0]  link_data;
    logic [CHUNKS-1:0] link_parity;

    // Return path, one pulse per drained word
    logic              credit_ret;

    modport tx (
        output link_valid, link_data, link_parity,
        input  credit_ret
    );

    modport rx (
        input  link_valid, link_data, link_parity,
        output credit_ret
    );

endinterface : credit_link_if

/* design/dataint_parity.sv */
// Combinational per-chunk parity generator and checker.
// Generation uses the parity output; checking compares parity_in and
// reports a flag per chunk on parity_err. parity_type 1 = even, 0 = odd.

`timescale 1ns/1ps

module dataint_parity #(
    parameter int CHUNKS = 4,
    parameter int WIDTH  = 32
) (
    input  logic [WIDTH-1:0]  data_in,
    input  logic [CHUNKS-1:0] parity_in,
    input  logic              parity_type,
    output logic [CHUNKS-1:0] parity,
    output logic [CHUNKS-1:0] parity_err
);

    // Nominal slice size; the remainder goes to the top slice
    localparam int SLICE_W = WIDTH / CHUNKS;

    for (genvar c = 0; c < CHUNKS; c++) begin : gen_chunk
        // Static slice bounds
        localparam int LO = c * SLICE_W;
        localparam int HI = (c == CHUNKS - 1) ? WIDTH - 1 : LO + SLICE_W - 1;

        logic slice_xor;

        // Plain reduction of the slice
        assign slice_xor = ^data_in[HI:LO];

        // Even sense keeps the XOR, odd sense inverts it
        assign parity[c] = parity_type ? slice_xor : ~slice_xor;

        // Mismatch against the supplied bit
        assign parity_err[c] = parity[c] ^ parity_in[c];
    end

endmodule : dataint_parity

/* design/parity_link_pkg.sv */
// Shared widths, depth and vector types for the parity-protected word link.
// Modules import this package in their body, or use scoped names in headers.

package parity_link_pkg;

    // ------------------------------------------------------------------------
    // Default link geometry
    // ------------------------------------------------------------------------

    // Data word width in bits
    localparam int LINK_WIDTH = 32;

    // Number of parity chunks per word
    localparam int LINK_CHUNKS = 4;

    // Receive buffer entries, also the credits the transmitter starts with
    localparam int LINK_DEPTH = 4;

    // Credit counter width, enough for a depth of 16
    localparam int CREDIT_W = 5;

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------

    // One data word at the default width
    typedef logic [LINK_WIDTH-1:0] link_data_t;

    // Parity bits, injection mask or error flags, one bit per chunk
    typedef logic [LINK_CHUNKS-1:0] link_par_t;

    // Transmitter credit count
    typedef logic [CREDIT_W-1:0] credit_cnt_t;

endpackage : parity_link_pkg
